// File: Makefile
VERILATOR  ?= verilator
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
TB_TOP     := tb_kinpira
RTL_TOP    := kinpira
FILELIST   := kinpira.f
PASS_MSG   := Simulation completed successfully

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TB_TOP))"; echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// File: core_select.sv
`timescale 1ns/1ps

module core_select
  import kinpira_reg_pkg::*;
  import kinpira_data_pkg::*;
(
  input  logic      clk,
  input  logic      xrst,
  input  which_e    which,
  input  logic      req,
  input  logic      fc_ack,
  output logic      ack,
  output logic      fc_req,
  input  logic      host_img_we,
  input  img_addr_t host_img_addr,
  input  data_t     host_img_wdata,
  input  logic      fc_img_we,
  input  img_addr_t fc_img_addr,
  input  data_t     fc_img_wdata,
  output logic      mem_we,
  output img_addr_t mem_addr,
  output data_t     mem_wdata
);

  logic fc_sel;

  // Reserved which value falls through to the host
  assign fc_sel = (which == WHICH_FC);

  assign fc_req = fc_sel & req;

  // Host never waits while it owns the memory
  assign ack = fc_sel ? fc_ack : 1'b1;

  assign mem_we    = fc_sel ? fc_img_we    : host_img_we;
  assign mem_addr  = fc_sel ? fc_img_addr  : host_img_addr;
  assign mem_wdata = fc_sel ? fc_img_wdata : host_img_wdata;

  // Host must not take the port back while the engine is still writing
  a_fc_write_owned: assert property (@(posedge clk) disable iff (!xrst)
    fc_img_we |-> fc_sel);

endmodule

// File: fc_engine.sv
`timescale 1ns/1ps
`include "kinpira_consts.svh"

module fc_engine
  import kinpira_data_pkg::*;
(
  input  logic       clk,
  input  logic       xrst,
  input  logic       req,
  input  img_addr_t  in_offset,
  input  img_addr_t  out_offset,
  input  net_addr_t  net_offset,
  input  layer_len_t total_out,
  input  layer_len_t total_in,
  input  data_t      img_rdata,
  input  data_t      net_rdata,
  output logic       ack,
  output logic       img_we,
  output img_addr_t  img_addr,
  output data_t      img_wdata,
  output net_addr_t  net_addr
);

  typedef enum logic [1:0] {S_IDLE, S_FETCH, S_ACC, S_WRITE} state_e;

  state_e                      state;
  logic                        req_d;
  logic                        start;
  layer_len_t                  o_cnt;
  layer_len_t                  i_cnt;
  net_addr_t                   net_ptr;
  logic                        d_valid;
  logic                        d_bias;
  logic signed [2*`DWIDTH-1:0] prod;
  acc_t                        acc;
  acc_t                        acc_sh;

  assign start = req & ~req_d & (state == S_IDLE);

  always_ff @(posedge clk) begin
    if (!xrst) begin
      state   <= S_IDLE;
      req_d   <= 1'b0;
      ack     <= 1'b1;
      o_cnt   <= '0;
      i_cnt   <= '0;
      net_ptr <= '0;
      d_valid <= 1'b0;
      d_bias  <= 1'b0;
    end else begin
      req_d   <= req;
      // Read data for the pair issued now arrives next cycle
      d_valid <= (state == S_FETCH);
      d_bias  <= (i_cnt == total_in);
      case (state)
        S_IDLE: begin
          if (start) begin
            state   <= S_FETCH;
            ack     <= 1'b0;
            o_cnt   <= '0;
            i_cnt   <= '0;
            net_ptr <= net_offset;
          end
        end
        S_FETCH: begin
          // Weights of all outputs packed back to back with the bias last
          net_ptr <= net_ptr + net_addr_t'(1);
          if (i_cnt == total_in) begin
            state <= S_ACC;
          end else begin
            i_cnt <= i_cnt + layer_len_t'(1);
          end
        end
        S_ACC: state <= S_WRITE;
        S_WRITE: begin
          i_cnt <= '0;
          if (o_cnt == total_out - layer_len_t'(1)) begin
            state <= S_IDLE;
            ack   <= 1'b1;
          end else begin
            o_cnt <= o_cnt + layer_len_t'(1);
            state <= S_FETCH;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  assign prod = img_rdata * net_rdata;

  // MAC stage cleared before each output
  always_ff @(posedge clk) begin
    if (start || state == S_WRITE) begin
      acc <= '0;
    end else if (d_valid) begin
      acc <= acc + (d_bias ? acc_t'(net_rdata) : acc_t'(prod));
    end
  end

  assign acc_sh    = acc >>> `FRAC_BITS;
  assign img_wdata = acc_sh[`DWIDTH-1:0];

  assign img_we   = (state == S_WRITE);
  assign img_addr = (state == S_WRITE) ? out_offset + img_addr_t'(o_cnt)
                                       : in_offset + img_addr_t'(i_cnt);
  assign net_addr = net_ptr;

  a_ack_low_busy: assert property (@(posedge clk) disable iff (!xrst)
    (state != S_IDLE) |-> !ack);

  a_no_write_done: assert property (@(posedge clk) disable iff (!xrst)
    ack |-> !img_we);

endmodule

// File: kinpira.f
+incdir+.
kinpira_reg_pkg.sv
kinpira_data_pkg.sv
mem_sp.sv
param_regs.sv
core_select.sv
fc_engine.sv
kinpira.sv
tb_kinpira.sv

// File: kinpira.sv
`timescale 1ns/1ps
`include "kinpira_consts.svh"

module kinpira
  import kinpira_reg_pkg::*;
  import kinpira_data_pkg::*;
(
  input  logic                   clk,
  input  logic                   xrst,
  input  logic                   reg_we,
  input  logic [`REG_ADDR_W-1:0] reg_addr,
  input  reg_word_t              reg_wdata,
  output reg_word_t              reg_rdata,
  input  logic                   img_we,
  input  img_addr_t              img_addr,
  input  data_t                  img_wdata,
  output data_t                  img_rdata,
  input  logic                   net_we,
  input  net_addr_t              net_addr,
  input  data_t                  net_wdata
);

  which_e     which;
  logic       req;
  img_addr_t  in_offset;
  img_addr_t  out_offset;
  net_addr_t  net_offset;
  layer_len_t total_out;
  layer_len_t total_in;
  logic       ack;
  logic       fc_req;
  logic       fc_ack;
  logic       fc_img_we;
  img_addr_t  fc_img_addr;
  data_t      fc_img_wdata;
  net_addr_t  fc_net_addr;
  logic       mem_we;
  img_addr_t  mem_addr;
  data_t      mem_wdata;
  data_t      net_rdata;
  net_addr_t  net_mem_addr;

  // Host weight writes take the port over engine reads
  assign net_mem_addr = net_we ? net_addr : fc_net_addr;

  param_regs param_regs_inst (
    .clk, .xrst, .reg_we, .reg_addr, .reg_wdata, .reg_rdata, .ack,
    .which, .req, .in_offset, .out_offset, .net_offset, .total_out, .total_in
  );

  core_select core_select_inst (
    .clk, .xrst, .which, .req, .fc_ack, .ack, .fc_req,
    .host_img_we    (img_we),
    .host_img_addr  (img_addr),
    .host_img_wdata (img_wdata),
    .fc_img_we, .fc_img_addr, .fc_img_wdata,
    .mem_we, .mem_addr, .mem_wdata
  );

  fc_engine fc_engine_inst (
    .clk, .xrst,
    .req       (fc_req),
    .in_offset, .out_offset, .net_offset, .total_out, .total_in,
    .img_rdata, .net_rdata,
    .ack       (fc_ack),
    .img_we    (fc_img_we),
    .img_addr  (fc_img_addr),
    .img_wdata (fc_img_wdata),
    .net_addr  (fc_net_addr)
  );

  mem_sp #(.word_t(data_t), .DEPTH_LOG(`IMGSIZE)) img_mem (
    .clk, .we(mem_we), .addr(mem_addr), .wdata(mem_wdata), .rdata(img_rdata)
  );

  mem_sp #(.word_t(data_t), .DEPTH_LOG(`NETSIZE)) net_mem (
    .clk, .we(net_we), .addr(net_mem_addr), .wdata(net_wdata), .rdata(net_rdata)
  );

endmodule

// File: kinpira_consts.svh
`ifndef KINPIRA_CONSTS_SVH
`define KINPIRA_CONSTS_SVH

// Data path widths
`define DWIDTH 16
`define LWIDTH 10

// Image and weight memory address widths
`define IMGSIZE 12
`define NETSIZE 12

// Fixed point fraction bits dropped from each sum
`define FRAC_BITS 8

// Host register index width
`define REG_ADDR_W 5

`endif

// File: kinpira_data_pkg.sv
`include "kinpira_consts.svh"

package kinpira_data_pkg;

  typedef logic signed [`DWIDTH-1:0] data_t;

  // Wide enough for total_in products plus the bias
  typedef logic signed [2*`DWIDTH+`LWIDTH-1:0] acc_t;

  typedef logic [`IMGSIZE-1:0] img_addr_t;
  typedef logic [`NETSIZE-1:0] net_addr_t;
  typedef logic [`LWIDTH-1:0] layer_len_t;

endpackage

// File: kinpira_reg_pkg.sv
`include "kinpira_consts.svh"

package kinpira_reg_pkg;

  typedef logic [31:0] reg_word_t;

  // Owner of the image memory port
  typedef enum logic [1:0] {
    WHICH_HOST = 2'd0,
    WHICH_RSVD = 2'd1,
    WHICH_FC   = 2'd2
  } which_e;

  typedef enum logic [`REG_ADDR_W-1:0] {
    REG_WHICH      = 0,
    REG_REQ        = 1,
    REG_IN_OFFSET  = 2,
    REG_OUT_OFFSET = 3,
    REG_NET_OFFSET = 4,
    REG_TOTAL_OUT  = 5,
    REG_TOTAL_IN   = 6,
    REG_ACK        = 30,
    REG_WHICH_RB   = 31
  } reg_idx_e;

endpackage

// File: mem_sp.sv
`timescale 1ns/1ps

module mem_sp #(
  parameter type word_t    = logic [31:0],
  parameter int  DEPTH_LOG = 12
) (
  input  logic                 clk,
  input  logic                 we,
  input  logic [DEPTH_LOG-1:0] addr,
  input  word_t                wdata,
  output word_t                rdata
);

  word_t mem [0:2**DEPTH_LOG-1];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= wdata;
    end
  end

  // Read returns the old word on a same cycle write
  always_ff @(posedge clk) begin
    rdata <= mem[addr];
  end

endmodule

// File: param_regs.sv
`timescale 1ns/1ps
`include "kinpira_consts.svh"

module param_regs
  import kinpira_reg_pkg::*;
  import kinpira_data_pkg::*;
(
  input  logic                   clk,
  input  logic                   xrst,
  input  logic                   reg_we,
  input  logic [`REG_ADDR_W-1:0] reg_addr,
  input  reg_word_t              reg_wdata,
  output reg_word_t              reg_rdata,
  input  logic                   ack,
  output which_e                 which,
  output logic                   req,
  output img_addr_t              in_offset,
  output img_addr_t              out_offset,
  output net_addr_t              net_offset,
  output layer_len_t             total_out,
  output layer_len_t             total_in
);

  which_e which_rb;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      which      <= WHICH_HOST;
      req        <= 1'b0;
      in_offset  <= '0;
      out_offset <= '0;
      net_offset <= '0;
      total_out  <= '0;
      total_in   <= '0;
    end else if (reg_we) begin
      case (reg_idx_e'(reg_addr))
        REG_WHICH:      which      <= which_e'(reg_wdata[1:0]);
        REG_REQ:        req        <= reg_wdata[0];
        REG_IN_OFFSET:  in_offset  <= reg_wdata[`IMGSIZE-1:0];
        REG_OUT_OFFSET: out_offset <= reg_wdata[`IMGSIZE-1:0];
        REG_NET_OFFSET: net_offset <= reg_wdata[`NETSIZE-1:0];
        REG_TOTAL_OUT:  total_out  <= reg_wdata[`LWIDTH-1:0];
        REG_TOTAL_IN:   total_in   <= reg_wdata[`LWIDTH-1:0];
        default: ;
      endcase
    end
  end

  // Readback lags the address by one cycle
  always_ff @(posedge clk) begin
    if (!xrst) begin
      which_rb  <= WHICH_HOST;
      reg_rdata <= '0;
    end else begin
      which_rb <= which;
      case (reg_idx_e'(reg_addr))
        REG_WHICH:      reg_rdata <= reg_word_t'(which);
        REG_REQ:        reg_rdata <= reg_word_t'(req);
        REG_IN_OFFSET:  reg_rdata <= reg_word_t'(in_offset);
        REG_OUT_OFFSET: reg_rdata <= reg_word_t'(out_offset);
        REG_NET_OFFSET: reg_rdata <= reg_word_t'(net_offset);
        REG_TOTAL_OUT:  reg_rdata <= reg_word_t'(total_out);
        REG_TOTAL_IN:   reg_rdata <= reg_word_t'(total_in);
        REG_ACK:        reg_rdata <= reg_word_t'(ack);
        REG_WHICH_RB:   reg_rdata <= reg_word_t'(which_rb);
        default:        reg_rdata <= '0;
      endcase
    end
  end

  a_rdata_known: assert property (@(posedge clk) disable iff (!xrst)
    !$isunknown(reg_rdata));

endmodule

// File: tb_kinpira.sv
`timescale 1ns/1ps
`include "kinpira_consts.svh"

module tb_kinpira
  import kinpira_reg_pkg::*;
  import kinpira_data_pkg::*;
();

  logic                   clk;
  logic                   xrst;
  logic                   reg_we;
  logic [`REG_ADDR_W-1:0] reg_addr;
  logic [31:0]            reg_wdata;
  logic [31:0]            reg_rdata;
  logic                   img_we;
  img_addr_t              img_addr;
  data_t                  img_wdata;
  data_t                  img_rdata;
  logic                   net_we;
  net_addr_t              net_addr;
  data_t                  net_wdata;

  int          errors;
  int          checks;
  int          tests;
  int          tests_failed;
  int          errors_at_start;
  logic [31:0] rng;
  logic [31:0] rd;
  data_t       got;
  data_t       xin [0:15];
  data_t       wt [0:127];

  kinpira kinpira_inst (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Engine answers a new request by dropping ack on the next cycle
  a_ack_drop: assert property (@(posedge clk) disable iff (!xrst)
    $rose(kinpira_inst.fc_req) |=> !kinpira_inst.ack)
    else begin
      $display("Ack did not drop on the cycle after the engine request rose");
      errors++;
    end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic data_t rand_word();
    rng = xorshift(rng);
    return rng[15:0];
  endfunction

  // Bias plus products followed by the fixed point shift and truncation
  function automatic data_t expected_out(input int o, input int n_in);
    longint sum;
    longint shifted;
    int     base;
    int     i;
    base = o * (n_in + 1);
    sum = longint'(wt[base + n_in]);
    for (i = 0; i < n_in; i++) begin
      sum += longint'(xin[i]) * longint'(wt[base + i]);
    end
    shifted = sum >>> `FRAC_BITS;
    return shifted[`DWIDTH-1:0];
  endfunction

  task automatic check_equal(input string name, input logic [31:0] exp,
                             input logic [31:0] val);
    checks++;
    assert (val === exp) else begin
      $display("Fail %s exp %h got %h", name, exp, val);
      errors++;
    end
  endtask

  task automatic reg_write(input logic [`REG_ADDR_W-1:0] a, input logic [31:0] d);
    @(posedge clk);
    reg_we    <= 1'b1;
    reg_addr  <= a;
    reg_wdata <= d;
    @(posedge clk);
    reg_we <= 1'b0;
  endtask

  task automatic reg_read(input logic [`REG_ADDR_W-1:0] a, output logic [31:0] d);
    @(posedge clk);
    reg_addr <= a;
    @(posedge clk);
    @(negedge clk);
    d = reg_rdata;
  endtask

  task automatic img_write(input img_addr_t a, input data_t d);
    @(posedge clk);
    img_we    <= 1'b1;
    img_addr  <= a;
    img_wdata <= d;
    @(posedge clk);
    img_we <= 1'b0;
  endtask

  task automatic img_read(input img_addr_t a, output data_t d);
    @(posedge clk);
    img_addr <= a;
    @(posedge clk);
    @(negedge clk);
    d = img_rdata;
  endtask

  task automatic net_write(input net_addr_t a, input data_t d);
    @(posedge clk);
    net_we    <= 1'b1;
    net_addr  <= a;
    net_wdata <= d;
    @(posedge clk);
    net_we <= 1'b0;
  endtask

  task automatic reg_check(input logic [`REG_ADDR_W-1:0] a, input logic [31:0] wval,
                           input logic [31:0] exp);
    reg_write(a, wval);
    reg_read(a, rd);
    check_equal("reg_rdata", exp, rd);
  endtask

  task automatic finish_run();
    $display("Tests %0d, failed %0d, checks %0d, errors %0d",
             tests, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  endtask

  task automatic wait_ack(input logic target, input int limit);
    int          n;
    logic [31:0] d;
    n = 0;
    reg_read(REG_ACK, d);
    while (d[0] !== target && n < limit) begin
      n++;
      reg_read(REG_ACK, d);
    end
    if (d[0] !== target) begin
      $display("Timeout while polling ack for the value %0d", target);
      errors++;
    end
  endtask

  task automatic begin_test();
    errors_at_start = errors;
  endtask

  task automatic end_test(input string name);
    tests++;
    if (errors != errors_at_start) begin
      tests_failed++;
      $display("Test %0d %s failed", tests, name);
    end else begin
      $display("Test %0d %s passed", tests, name);
    end
  endtask

  task automatic run_layer(input int in_off, input int out_off, input int net_off,
                           input int n_in, input int n_out);
    int    i;
    data_t d;
    for (i = 0; i < n_in; i++) begin
      xin[i] = rand_word();
      img_write(img_addr_t'(in_off + i), xin[i]);
    end
    // Per output n_in weights then the bias
    for (i = 0; i < n_out * (n_in + 1); i++) begin
      wt[i] = rand_word();
      net_write(net_addr_t'(net_off + i), wt[i]);
    end
    reg_write(REG_IN_OFFSET, in_off);
    reg_write(REG_OUT_OFFSET, out_off);
    reg_write(REG_NET_OFFSET, net_off);
    reg_write(REG_TOTAL_IN, n_in);
    reg_write(REG_TOTAL_OUT, n_out);
    reg_write(REG_WHICH, WHICH_FC);
    reg_write(REG_REQ, 1);
    wait_ack(1'b0, 8);
    wait_ack(1'b1, 200);
    reg_write(REG_REQ, 0);
    reg_write(REG_WHICH, WHICH_HOST);
    for (i = 0; i < n_out; i++) begin
      img_read(img_addr_t'(out_off + i), d);
      check_equal("img_rdata", expected_out(i, n_in), d);
    end
    for (i = 0; i < n_in; i++) begin
      img_read(img_addr_t'(in_off + i), d);
      check_equal("img_rdata", xin[i], d);
    end
  endtask

  initial begin
    xrst      = 1'b0;
    reg_we    = 1'b0;
    reg_addr  = '0;
    reg_wdata = '0;
    img_we    = 1'b0;
    img_addr  = '0;
    img_wdata = '0;
    net_we    = 1'b0;
    net_addr  = '0;
    net_wdata = '0;
    rng       = 32'hd2a8736b;
    errors    = 0;
    checks    = 0;
    tests     = 0;
    tests_failed = 0;
    repeat (5) @(posedge clk);
    xrst <= 1'b1;

    begin_test();
    reg_read(REG_ACK, rd);
    check_equal("reg_rdata", 1, rd);
    reg_read(REG_WHICH_RB, rd);
    check_equal("reg_rdata", 0, rd);
    end_test("reset state");

    begin_test();
    reg_check(REG_IN_OFFSET, 32'hffff_fabc, 32'h0000_0abc);
    reg_check(REG_OUT_OFFSET, 32'h1234_5678, 32'h0000_0678);
    reg_check(REG_NET_OFFSET, 32'h0000_1fff, 32'h0000_0fff);
    reg_check(REG_TOTAL_OUT, 32'h0000_07ff, 32'h0000_03ff);
    reg_check(REG_TOTAL_IN, 32'hdead_beef, 32'h0000_02ef);
    reg_check(REG_REQ, 32'h0000_0003, 32'h0000_0001);
    reg_check(REG_REQ, 32'h0000_0000, 32'h0000_0000);
    reg_check(REG_WHICH, 32'h0000_0006, 32'h0000_0002);
    reg_read(REG_WHICH_RB, rd);
    check_equal("reg_rdata", WHICH_FC, rd);
    reg_check(REG_WHICH, WHICH_HOST, WHICH_HOST);
    reg_read(REG_WHICH_RB, rd);
    check_equal("reg_rdata", WHICH_HOST, rd);
    end_test("register access");

    begin_test();
    for (int i = 0; i < 8; i++) begin
      xin[i] = rand_word();
      img_write(img_addr_t'(12'h800 + i * 37), xin[i]);
    end
    for (int i = 0; i < 8; i++) begin
      img_read(img_addr_t'(12'h800 + i * 37), got);
      check_equal("img_rdata", xin[i], got);
    end
    end_test("image round trip");

    begin_test();
    run_layer(12'h010, 12'h100, 12'h000, 4, 3);
    end_test("first layer");

    begin_test();
    img_write(12'h050, 16'h1357);
    reg_write(REG_WHICH, WHICH_FC);
    img_write(12'h050, 16'hbeef);
    reg_write(REG_WHICH, WHICH_HOST);
    img_read(12'h050, got);
    check_equal("img_rdata", 16'h1357, got);
    end_test("host isolation");

    begin_test();
    run_layer(12'h200, 12'h300, 12'h040, 7, 5);
    end_test("second layer");

    finish_run();
  end

endmodule
